// File: include/rv_defines.svh
// Width, opcode, function code and NOP macros for the RV32I core
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Widths
`define RV_XLEN   32
`define RV_REG_AW 5

// Major opcodes
`define RV_OP_REG   7'b0110011
`define RV_OP_IMM   7'b0010011
`define RV_OP_LOAD  7'b0000011
`define RV_OP_STORE 7'b0100011

// Function-3 codes
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_XOR  3'b100
`define RV_F3_SRL  3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111
`define RV_F3_WORD 3'b010

// Function-7 of sub and sra
`define RV_F7_ALT 7'b0100000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: logic/rv_pkg.sv
// Core types: data word, register index, ALU op, writeback source, stage payloads
`include "rv_defines.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0]   word_t;
	typedef logic [`RV_REG_AW-1:0] reg_idx_t;

	// ADD must stay zero so a bubble decodes as a harmless add
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7,
		ALU_SRA = 4'd8
	} alu_op_e;

	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wb_src_e;

	// --------------------
	// Stage payloads

	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    op_a;
		word_t    op_b;
		word_t    imm;
		logic     use_imm;
		alu_op_e  alu_op;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		wb_src_e  wb_src;
	} id_ex_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    alu;
		word_t    store_data;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		wb_src_e  wb_src;
	} ex_me_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    alu;
		word_t    load_data;
		logic     reg_write;
		wb_src_e  wb_src;
	} me_wb_t;

	// Writeback bus
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} wb_t;

	// Word addressed data memory request
	typedef struct packed {
		logic                ren;
		logic                wen;
		logic [`RV_XLEN-3:0] addr;
		word_t               wdata;
	} dmem_req_t;

endpackage

// File: logic/rv_stage_reg.sv
// Generic pipeline stage register with hold and bubble insertion
`timescale 1ns/100ps

module rv_stage_reg #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_hold,
	input  logic i_bubble,
	input  T     i_d,
	output T     o_q
);

	// Hold wins over bubble, bubble is an all-zero payload
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_q <= '0;
		end else if (i_hold) begin
			o_q <= o_q;
		end else if (i_bubble) begin
			o_q <= '0;
		end else begin
			o_q <= i_d;
		end
	end

endmodule

// File: logic/rv_regfile.sv
// Register file: 31 writable registers, x0 tied to zero, write-through read bypass
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::wb_t      i_wb,
	input  rv_pkg::reg_idx_t i_rs1,
	input  rv_pkg::reg_idx_t i_rs2,
	output rv_pkg::word_t    o_rd1,
	output rv_pkg::word_t    o_rd2
);
	import rv_pkg::*;

	localparam int NREGS = 2 ** `RV_REG_AW;

	word_t regs [1:NREGS-1];

	// Same-cycle write shows up on the read port
	function automatic word_t read_port(input reg_idx_t idx);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (i_wb.valid && i_wb.rd == idx) begin
			val = i_wb.data;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_comb begin
		o_rd1 = read_port(i_rs1);
		o_rd2 = read_port(i_rs2);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.valid && i_wb.rd != '0) begin
			regs[i_wb.rd] <= i_wb.data;
		end
	end

endmodule

// File: logic/rv_decode.sv
// ID stage: instruction register, field split, immediates, control, reg read, load-use check
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_decode (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_inst_valid,
	input  rv_pkg::word_t  i_inst,
	input  logic           i_hold,
	input  rv_pkg::id_ex_t i_ex,
	input  rv_pkg::wb_t    i_wb,
	output logic           o_inst_ready,
	output rv_pkg::id_ex_t o_id_ex,
	output logic           o_load_stall
);
	import rv_pkg::*;

	word_t      inst_id;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	reg_idx_t   rd;
	word_t      rs1_val;
	word_t      rs2_val;
	word_t      imm_i;
	word_t      imm_s;
	logic       alt;
	logic       alu_ok;
	logic       supported;
	alu_op_e    alu_op;
	id_ex_t     ctrl;

	assign o_inst_ready = !i_hold && !o_load_stall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inst_id <= `RV_NOP;
		end else if (o_inst_ready) begin
			inst_id <= i_inst_valid ? i_inst : `RV_NOP;
		end
	end

	assign opcode = inst_id[6:0];
	assign rd     = inst_id[11:7];
	assign funct3 = inst_id[14:12];
	assign rs1    = inst_id[19:15];
	assign rs2    = inst_id[24:20];
	assign funct7 = inst_id[31:25];
	assign imm_i  = {{20{inst_id[31]}}, inst_id[31:20]};
	assign imm_s  = {{20{inst_id[31]}}, inst_id[31:25], inst_id[11:7]};
	assign alt    = (funct7 == `RV_F7_ALT);

	rv_regfile regfile0 (
		.clk   (clk),
		.rst_n (rst_n),
		.i_wb  (i_wb),
		.i_rs1 (rs1),
		.i_rs2 (rs2),
		.o_rd1 (rs1_val),
		.o_rd2 (rs2_val)
	);

	// --------------------
	// ALU op from funct3, sub only in register form
	always_comb begin
		alu_op = ALU_ADD;
		alu_ok = 1'b1;
		case (funct3)
			`RV_F3_ADD: alu_op = (opcode == `RV_OP_REG && alt) ? ALU_SUB : ALU_ADD;
			`RV_F3_SLL: alu_op = ALU_SLL;
			`RV_F3_SLT: alu_op = ALU_SLT;
			`RV_F3_XOR: alu_op = ALU_XOR;
			`RV_F3_SRL: alu_op = alt ? ALU_SRA : ALU_SRL;
			`RV_F3_OR:  alu_op = ALU_OR;
			`RV_F3_AND: alu_op = ALU_AND;
			default:    alu_ok = 1'b0;
		endcase
	end

	// Unused source fields stay zero so they never match a hazard
	always_comb begin
		ctrl         = '0;
		supported    = 1'b1;
		ctrl.rs1     = rs1;
		ctrl.rd      = rd;
		ctrl.op_a    = rs1_val;
		ctrl.op_b    = rs2_val;
		ctrl.imm     = imm_i;
		ctrl.use_imm = 1'b1;
		case (opcode)
			`RV_OP_REG: begin
				ctrl.rs2       = rs2;
				ctrl.use_imm   = 1'b0;
				ctrl.alu_op    = alu_op;
				ctrl.reg_write = 1'b1;
				supported      = alu_ok;
			end
			`RV_OP_IMM: begin
				ctrl.alu_op    = alu_op;
				ctrl.reg_write = 1'b1;
				supported      = alu_ok;
			end
			`RV_OP_LOAD: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.wb_src    = WB_MEM;
				supported      = (funct3 == `RV_F3_WORD);
			end
			`RV_OP_STORE: begin
				ctrl.rs2       = rs2;
				ctrl.rd        = '0;
				ctrl.imm       = imm_s;
				ctrl.mem_write = 1'b1;
				supported      = (funct3 == `RV_F3_WORD);
			end
			default: supported = 1'b0;
		endcase
	end

	assign o_id_ex = supported ? ctrl : '0;

	// Load in EX feeding the instruction in ID
	assign o_load_stall = i_ex.mem_read && (i_ex.rd != '0) &&
		((i_ex.rd == o_id_ex.rs1) || (i_ex.rd == o_id_ex.rs2));

endmodule

// File: logic/rv_execute.sv
// EX stage: operand forwarding, operand B select and the ALU
`timescale 1ns/100ps

module rv_execute (
	input  rv_pkg::id_ex_t i_ex,
	input  rv_pkg::ex_me_t i_me,
	input  rv_pkg::wb_t    i_wb,
	output rv_pkg::ex_me_t o_ex_me
);
	import rv_pkg::*;

	word_t src_a;
	word_t src_b;
	word_t opnd_b;
	word_t alu_out;

	// ME result is younger, so it wins over writeback
	function automatic word_t forward(
		input reg_idx_t rs,
		input word_t    reg_val,
		input ex_me_t   me,
		input wb_t      wb
	);
		word_t val;
		val = reg_val;
		if (rs != '0 && me.reg_write && me.rd == rs) begin
			val = me.alu;
		end else if (wb.valid && wb.rd == rs) begin
			val = wb.data;
		end
		return val;
	endfunction

	assign src_a  = forward(i_ex.rs1, i_ex.op_a, i_me, i_wb);
	assign src_b  = forward(i_ex.rs2, i_ex.op_b, i_me, i_wb);
	assign opnd_b = i_ex.use_imm ? i_ex.imm : src_b;

	// --------------------
	// ALU
	always_comb begin
		case (i_ex.alu_op)
			ALU_ADD: alu_out = src_a + opnd_b;
			ALU_SUB: alu_out = src_a - opnd_b;
			ALU_AND: alu_out = src_a & opnd_b;
			ALU_OR:  alu_out = src_a | opnd_b;
			ALU_XOR: alu_out = src_a ^ opnd_b;
			ALU_SLT: alu_out = ($signed(src_a) < $signed(opnd_b)) ? word_t'(1) : '0;
			ALU_SLL: alu_out = src_a << opnd_b[4:0];
			ALU_SRL: alu_out = src_a >> opnd_b[4:0];
			ALU_SRA: alu_out = word_t'($signed(src_a) >>> opnd_b[4:0]);
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		o_ex_me            = '0;
		o_ex_me.rd         = i_ex.rd;
		o_ex_me.alu        = alu_out;
		o_ex_me.store_data = src_b;
		o_ex_me.reg_write  = i_ex.reg_write;
		o_ex_me.mem_read   = i_ex.mem_read;
		o_ex_me.mem_write  = i_ex.mem_write;
		o_ex_me.wb_src     = i_ex.wb_src;
	end

endmodule

// File: logic/rv_result.sv
// ME and WB stages: data memory request, load data capture, writeback select
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_result (
	input  rv_pkg::ex_me_t    i_me,
	input  rv_pkg::me_wb_t    i_wb_in,
	input  rv_pkg::word_t     i_dmem_rdata,
	input  logic              i_dmem_stall,
	output rv_pkg::dmem_req_t o_dmem,
	output rv_pkg::me_wb_t    o_me_wb,
	output rv_pkg::wb_t       o_wb
);
	import rv_pkg::*;

	// ALU result is the byte address
	always_comb begin
		o_dmem       = '0;
		o_dmem.ren   = i_me.mem_read;
		o_dmem.wen   = i_me.mem_write;
		o_dmem.addr  = i_me.alu[`RV_XLEN-1:2];
		o_dmem.wdata = i_me.store_data;
	end

	always_comb begin
		o_me_wb           = '0;
		o_me_wb.rd        = i_me.rd;
		o_me_wb.alu       = i_me.alu;
		o_me_wb.load_data = i_dmem_rdata;
		o_me_wb.reg_write = i_me.reg_write;
		o_me_wb.wb_src    = i_me.wb_src;
	end

	// --------------------
	// Writeback, suppressed for x0 and while memory holds the pipe
	always_comb begin
		o_wb       = '0;
		o_wb.valid = i_wb_in.reg_write && (i_wb_in.rd != '0) && !i_dmem_stall;
		o_wb.rd    = i_wb_in.rd;
		o_wb.data  = (i_wb_in.wb_src == WB_MEM) ? i_wb_in.load_data : i_wb_in.alu;
	end

endmodule

// File: logic/rv_core.sv
// Four-stage RV32I core top: stage logic, pipeline registers and stall wiring
`timescale 1ns/100ps

module rv_core (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_inst_valid,
	input  rv_pkg::word_t     i_inst,
	output logic              o_inst_ready,
	output rv_pkg::dmem_req_t o_dmem,
	input  rv_pkg::word_t     i_dmem_rdata,
	input  logic              i_dmem_stall,
	output rv_pkg::wb_t       o_wb
);
	import rv_pkg::*;

	id_ex_t id_ex_d;
	id_ex_t id_ex_q;
	ex_me_t ex_me_d;
	ex_me_t ex_me_q;
	me_wb_t me_wb_d;
	me_wb_t me_wb_q;
	logic   load_stall;

	// --------------------
	// ID
	rv_decode decode0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.i_hold       (i_dmem_stall),
		.i_ex         (id_ex_q),
		.i_wb         (o_wb),
		.o_inst_ready (o_inst_ready),
		.o_id_ex      (id_ex_d),
		.o_load_stall (load_stall)
	);

	// Load-use stall drops a bubble into EX
	rv_stage_reg #(.T(id_ex_t)) id_ex_reg0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_hold   (i_dmem_stall),
		.i_bubble (load_stall),
		.i_d      (id_ex_d),
		.o_q      (id_ex_q)
	);

	// --------------------
	// EX
	rv_execute execute0 (
		.i_ex    (id_ex_q),
		.i_me    (ex_me_q),
		.i_wb    (o_wb),
		.o_ex_me (ex_me_d)
	);

	rv_stage_reg #(.T(ex_me_t)) ex_me_reg0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_hold   (i_dmem_stall),
		.i_bubble (1'b0),
		.i_d      (ex_me_d),
		.o_q      (ex_me_q)
	);

	// --------------------
	// ME and WB
	rv_result result0 (
		.i_me         (ex_me_q),
		.i_wb_in      (me_wb_q),
		.i_dmem_rdata (i_dmem_rdata),
		.i_dmem_stall (i_dmem_stall),
		.o_dmem       (o_dmem),
		.o_me_wb      (me_wb_d),
		.o_wb         (o_wb)
	);

	rv_stage_reg #(.T(me_wb_t)) me_wb_reg0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_hold   (i_dmem_stall),
		.i_bubble (1'b0),
		.i_d      (me_wb_d),
		.o_q      (me_wb_q)
	);

endmodule

// File: verif/rv_core_tb.sv
// Testbench for rv_core with ISA reference model, data memory model, writeback and store checkers
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_core_tb;
	import rv_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      inst_valid;
	word_t     inst;
	logic      inst_ready;
	dmem_req_t dmem;
	word_t     dmem_rdata;
	logic      dmem_stall = 1'b0;
	wb_t       wb;

	word_t        ref_regs [32];
	word_t        ref_mem [256];
	word_t        dmem_arr [256];
	logic [36:0]  exp_q [$];
	logic [61:0]  st_q [$];
	logic [36:0]  wb_exp;
	logic [61:0]  st_exp;
	logic         stall_en;
	logic         stall_pick;
	int           last_wait;

	rv_core dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_inst_valid (inst_valid),
		.i_inst       (inst),
		.o_inst_ready (inst_ready),
		.o_dmem       (dmem),
		.i_dmem_rdata (dmem_rdata),
		.i_dmem_stall (dmem_stall),
		.o_wb         (wb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------
	// Reporting

	task automatic fail(input string what);
		$display("%s at %0t", what, $time);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// --------------------
	// Instruction encoders

	function automatic word_t op_r(input logic [2:0] f3, input logic alt,
		input int rd, input int rs1, input int rs2);
		return {(alt ? `RV_F7_ALT : 7'd0), rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_REG};
	endfunction

	function automatic word_t op_i(input logic [2:0] f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], `RV_OP_IMM};
	endfunction

	function automatic word_t ld(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], `RV_F3_WORD, rd[4:0], `RV_OP_LOAD};
	endfunction

	function automatic word_t st(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], `RV_F3_WORD, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic word_t fill_word(input int idx);
		return (word_t'(idx) * 32'h9e37_79b9) ^ 32'h0f0f_1234;
	endfunction

	// --------------------
	// ISA reference model

	function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			`RV_F3_ADD: return alt ? a - b : a + b;
			`RV_F3_SLL: return a << b[4:0];
			`RV_F3_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`RV_F3_XOR: return a ^ b;
			`RV_F3_SRL: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			`RV_F3_OR:  return a | b;
			`RV_F3_AND: return a & b;
			default:    return 32'd0;
		endcase
	endfunction

	task automatic model(input word_t ins);
		logic [2:0] f3;
		logic       alt;
		logic       wr;
		reg_idx_t   rd;
		word_t      a;
		word_t      b;
		word_t      ea;
		word_t      res;
		f3  = ins[14:12];
		rd  = ins[11:7];
		alt = (ins[31:25] == `RV_F7_ALT);
		a   = ref_regs[ins[19:15]];
		b   = ref_regs[ins[24:20]];
		wr  = 1'b0;
		res = '0;
		case (ins[6:0])
			`RV_OP_REG: begin
				wr  = (f3 != 3'b011);
				res = alu_model(f3, alt, a, b);
			end
			`RV_OP_IMM: begin
				wr  = (f3 != 3'b011);
				res = alu_model(f3, alt && f3 == `RV_F3_SRL, a, {{20{ins[31]}}, ins[31:20]});
			end
			`RV_OP_LOAD: begin
				ea  = a + {{20{ins[31]}}, ins[31:20]};
				wr  = (f3 == `RV_F3_WORD);
				res = ref_mem[ea[9:2]];
			end
			`RV_OP_STORE: begin
				ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				if (f3 == `RV_F3_WORD) begin
					ref_mem[ea[9:2]] = b;
					st_q.push_back({ea[31:2], b});
				end
			end
			default: wr = 1'b0;
		endcase
		if (wr && rd != '0) begin
			ref_regs[rd] = res;
			exp_q.push_back({rd, res});
		end
	endtask

	// --------------------
	// Memory model, stall source and writeback monitor

	// Read data is defined only while a read is requested
	assign dmem_rdata = dmem.ren ? dmem_arr[dmem.addr[7:0]] : 32'hbad0_bad0;

	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				dmem_arr[i] = fill_word(i);
			end
		end else if (dmem.wen && !dmem_stall) begin
			if (st_q.size() == 0) begin
				fail("Store performed with no store expected");
			end
			st_exp = st_q.pop_front();
			check("o_dmem.addr", word_t'(dmem.addr), word_t'(st_exp[61:32]));
			check("o_dmem.wdata", dmem.wdata, st_exp[31:0]);
			dmem_arr[dmem.addr[7:0]] = dmem.wdata;
		end
	end

	always @(posedge clk) begin
		stall_pick = stall_en && (($urandom % 3) == 0);
		#1;
		dmem_stall = stall_pick;
	end

	always @(negedge clk) begin
		if (rst_n && wb.valid) begin
			if (exp_q.size() == 0) begin
				fail("Writeback seen with no result expected");
			end
			wb_exp = exp_q.pop_front();
			check("o_wb.rd", word_t'(wb.rd), word_t'(wb_exp[36:32]));
			check("o_wb.data", wb.data, wb_exp[31:0]);
		end
	end

	// --------------------
	// Drive helpers

	task automatic issue(input word_t ins);
		int   waited;
		logic rdy;
		logic taken;
		waited     = 0;
		taken      = 1'b0;
		inst_valid = 1'b1;
		inst       = ins;
		while (!taken) begin
			@(negedge clk);
			rdy = inst_ready;
			@(posedge clk);
			if (rdy) begin
				taken = 1'b1;
			end else begin
				waited++;
				if (waited > 100) begin
					fail("Instruction was not accepted before the timeout");
				end
			end
		end
		last_wait = waited;
		model(ins);
		#1;
		inst_valid = 1'b0;
		inst       = `RV_NOP;
	endtask

	// Wait for all expected results, then let trailing bubbles pass
	task automatic drain();
		int t;
		t = 0;
		while (exp_q.size() != 0 || st_q.size() != 0) begin
			@(posedge clk);
			t++;
			if (t > 300) begin
				fail("Pipeline did not drain before the timeout");
			end
		end
		repeat (6) @(posedge clk);
		#1;
	endtask

	// --------------------
	// Directed tests

	task automatic reset_state();
		check("o_wb.valid", word_t'(wb.valid), 32'd0);
		check("o_dmem.ren", word_t'(dmem.ren), 32'd0);
		check("o_dmem.wen", word_t'(dmem.wen), 32'd0);
		check("o_inst_ready", word_t'(inst_ready), 32'd1);
	endtask

	task automatic alu_ops();
		issue(op_i(`RV_F3_ADD, 1, 0, -20));
		issue(op_i(`RV_F3_ADD, 2, 0, 3));
		for (int f = 0; f < 8; f++) begin
			if (f != 3) begin
				issue(op_r(3'(f), 1'b0, 10 + f, 1, 2));
				issue(op_r(3'(f), 1'b0, 18 + f, 2, 1));
				issue(op_i(3'(f), 26, 1, (f == 1 || f == 5) ? 4 : -300));
			end
		end
		issue(op_r(`RV_F3_ADD, 1'b1, 27, 1, 2));
		issue(op_r(`RV_F3_SRL, 1'b1, 28, 1, 2));
		issue(op_i(`RV_F3_SRL, 29, 1, 32'h404));
		drain();
	endtask

	task automatic dep_chains();
		for (int d = 1; d <= 4; d++) begin
			issue(op_i(`RV_F3_ADD, 11, 0, 100 * d + 7));
			for (int k = 1; k < d; k++) begin
				issue(op_i(`RV_F3_XOR, 25, 2, k));
			end
			issue(op_r(`RV_F3_ADD, 1'b1, 12, 11, 1));
			issue(op_r(`RV_F3_OR, 1'b0, 13, 2, 12));
		end
		drain();
	endtask

	task automatic load_store();
		issue(op_i(`RV_F3_ADD, 21, 0, 12'h123));
		issue(op_i(`RV_F3_ADD, 22, 0, -77));
		issue(st(21, 0, 16));
		issue(st(22, 0, 20));
		issue(ld(23, 0, 16));
		issue(ld(24, 0, 20));
		issue(ld(26, 0, 40));
		drain();
		issue(ld(23, 0, 20));
		issue(op_r(`RV_F3_ADD, 1'b0, 24, 23, 23));
		check("o_inst_ready stall cycles", word_t'(last_wait), 32'd0);
		issue(op_i(`RV_F3_ADD, 25, 0, 1));
		check("o_inst_ready stall cycles", word_t'(last_wait), 32'd1);
		drain();
	endtask

	task automatic stalled_memory();
		word_t r;
		stall_en = 1'b1;
		for (int i = 0; i < 40; i++) begin
			r = $urandom;
			case (r[1:0])
				2'd0: issue(op_i(`RV_F3_ADD, 1 + int'(r[3:2]), 0, int'(r[15:4])));
				2'd1: issue(st(1 + int'(r[3:2]), 0, int'(r[9:4]) * 4));
				2'd2: issue(ld(1 + int'(r[3:2]), 0, int'(r[9:4]) * 4));
				default: begin
					issue(ld(5, 0, int'(r[9:4]) * 4));
					issue(op_r(`RV_F3_ADD, 1'b0, 6, 5, 1));
				end
			endcase
		end
		stall_en = 1'b0;
		drain();
	endtask

	// x0 is read right behind each write to it
	task automatic x0_and_illegal();
		issue(op_i(`RV_F3_ADD, 0, 0, 123));
		issue(op_r(`RV_F3_ADD, 1'b0, 8, 0, 0));
		issue(op_r(`RV_F3_ADD, 1'b0, 0, 1, 2));
		issue(op_r(`RV_F3_OR, 1'b0, 8, 0, 1));
		// Unknown opcode aimed at x9
		issue(32'h0ab0_84ff);
		issue(op_r(3'b011, 1'b0, 9, 1, 2));
		issue(op_r(`RV_F3_ADD, 1'b0, 12, 9, 0));
		drain();
	endtask

	initial begin
		void'($urandom(32'ha150_f0b9));
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = `RV_NOP;
		stall_en   = 1'b0;
		last_wait  = 0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_state();
		alu_ops();
		dep_chains();
		load_store();
		stalled_memory();
		x0_and_illegal();
		if (exp_q.size() != 0 || st_q.size() != 0) begin
			fail("Expected results were left over at the end of the run");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// File: src.f
+incdir+include
logic/rv_pkg.sv
logic/rv_stage_reg.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
verif/rv_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = rv_core_tb
FILELIST  = src.f
OBJDIR    = obj_dir

SRCS = $(shell grep -v '^+' $(FILELIST)) include/rv_defines.svh
BIN  = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
